//--- common/hash2qid_pkg.sv
package hash2qid_pkg;

    // ------------------------------------------------------------
    // stream widths
    // ------------------------------------------------------------
    localparam int data_wid = 64;
    localparam int keep_wid = 8;
    localparam int tuser_wid = 16;

    // data, keep, last and tuser packed together as one word
    localparam int beat_wid = data_wid + keep_wid + 1 + tuser_wid;

    // ------------------------------------------------------------
    // queue lookup
    // ------------------------------------------------------------
    localparam int qid_wid = 12;
    localparam int tbl_index_wid = 7;
    localparam int tbl_depth = 128;
    localparam int num_hosts = 4;

    localparam logic [1:0] host_pf = 2'd0;
    localparam logic [1:0] host_vf0 = 2'd1;
    localparam logic [1:0] host_vf1 = 2'd2;
    localparam logic [1:0] host_vf2 = 2'd3;

    // ------------------------------------------------------------
    // register port and address map
    // ------------------------------------------------------------
    localparam int reg_addr_wid = 10;
    localparam int reg_data_wid = 32;

    localparam logic [reg_addr_wid-1:0] tbl_pf_base = 10'h000;
    localparam logic [reg_addr_wid-1:0] tbl_vf0_base = 10'h080;
    localparam logic [reg_addr_wid-1:0] tbl_vf1_base = 10'h100;
    localparam logic [reg_addr_wid-1:0] tbl_vf2_base = 10'h180;
    // per-host bases at 0x200 to 0x203
    localparam logic [reg_addr_wid-1:0] qbase_addr = 10'h200;

    // ------------------------------------------------------------
    // metadata
    // ------------------------------------------------------------
    typedef struct packed {
        logic [1:0]               host_if_id;
        logic [2:0]               reserved;
        logic [tbl_index_wid-1:0] tbl_index;
    } rss_hash_t;

    // hash on the way in, queue id on the way out
    typedef union packed {
        rss_hash_t          hash;
        logic [qid_wid-1:0] qid;
    } rss_word_u;

    typedef struct packed {
        logic [2:0] flags;
        logic       rss_enable;
        rss_word_u  rss_word;
    } tuser_meta_t;

endpackage

//--- hdl/stream_pipe_stage.sv
module stream_pipe_stage #(
    parameter int width = 8
) (
    input  logic             core_clk,
    input  logic             rst_n,

    input  logic             in_valid,
    output logic             in_ready,
    input  logic [width-1:0] in_payload,

    output logic             out_valid,
    input  logic             out_ready,
    output logic [width-1:0] out_payload
);

    // take a new word when empty or when the held one leaves now
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge core_clk) begin
        if (in_valid && in_ready) begin
            out_payload <= in_payload;
        end
    end

    // ------------------------------------------------------------
    // handshake checks
    // ------------------------------------------------------------
    payload_stable_a : assert property (
        @(posedge core_clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_payload)
    ) else $error("payload changed while stalled");

endmodule

//--- hash2qid/hash2qid_regs.sv
module hash2qid_regs (
    input  logic                                  core_clk,
    input  logic                                  rst_n,

    input  logic                                  reg_wr_en,
    input  logic                                  reg_rd_en,
    input  logic [hash2qid_pkg::reg_addr_wid-1:0] reg_addr,
    input  logic [hash2qid_pkg::reg_data_wid-1:0] reg_wdata,
    output logic [hash2qid_pkg::reg_data_wid-1:0] reg_rdata,
    output logic                                  reg_rd_valid,

    output logic [hash2qid_pkg::qid_wid-1:0]      pf_table  [hash2qid_pkg::tbl_depth],
    output logic [hash2qid_pkg::qid_wid-1:0]      vf0_table [hash2qid_pkg::tbl_depth],
    output logic [hash2qid_pkg::qid_wid-1:0]      vf1_table [hash2qid_pkg::tbl_depth],
    output logic [hash2qid_pkg::qid_wid-1:0]      vf2_table [hash2qid_pkg::tbl_depth],
    output logic [hash2qid_pkg::qid_wid-1:0]      qbase     [hash2qid_pkg::num_hosts]
);
    import hash2qid_pkg::*;

    logic                     sel_pf;
    logic                     sel_vf0;
    logic                     sel_vf1;
    logic                     sel_vf2;
    logic                     sel_qbase;
    logic [tbl_index_wid-1:0] entry_idx;
    logic [1:0]               host_idx;
    logic [qid_wid-1:0]       rd_entry;

    // ------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------
    // tables are 128-word windows, bases a 4-word window
    assign sel_pf = reg_addr[reg_addr_wid-1:tbl_index_wid]
        == tbl_pf_base[reg_addr_wid-1:tbl_index_wid];
    assign sel_vf0 = reg_addr[reg_addr_wid-1:tbl_index_wid]
        == tbl_vf0_base[reg_addr_wid-1:tbl_index_wid];
    assign sel_vf1 = reg_addr[reg_addr_wid-1:tbl_index_wid]
        == tbl_vf1_base[reg_addr_wid-1:tbl_index_wid];
    assign sel_vf2 = reg_addr[reg_addr_wid-1:tbl_index_wid]
        == tbl_vf2_base[reg_addr_wid-1:tbl_index_wid];
    assign sel_qbase = reg_addr[reg_addr_wid-1:2] == qbase_addr[reg_addr_wid-1:2];

    assign entry_idx = reg_addr[tbl_index_wid-1:0];
    assign host_idx = reg_addr[1:0];

    // ------------------------------------------------------------
    // writes
    // ------------------------------------------------------------
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < tbl_depth; i++) begin
                pf_table[i] <= '0;
                vf0_table[i] <= '0;
                vf1_table[i] <= '0;
                vf2_table[i] <= '0;
            end
            for (int h = 0; h < num_hosts; h++) begin
                qbase[h] <= '0;
            end
        end else if (reg_wr_en) begin
            if (sel_pf) begin
                pf_table[entry_idx] <= reg_wdata[qid_wid-1:0];
            end else if (sel_vf0) begin
                vf0_table[entry_idx] <= reg_wdata[qid_wid-1:0];
            end else if (sel_vf1) begin
                vf1_table[entry_idx] <= reg_wdata[qid_wid-1:0];
            end else if (sel_vf2) begin
                vf2_table[entry_idx] <= reg_wdata[qid_wid-1:0];
            end else if (sel_qbase) begin
                qbase[host_idx] <= reg_wdata[qid_wid-1:0];
            end
        end
    end

    // ------------------------------------------------------------
    // reads, one cycle after the request
    // ------------------------------------------------------------
    always_comb begin
        rd_entry = '0;
        if (sel_pf) begin
            rd_entry = pf_table[entry_idx];
        end else if (sel_vf0) begin
            rd_entry = vf0_table[entry_idx];
        end else if (sel_vf1) begin
            rd_entry = vf1_table[entry_idx];
        end else if (sel_vf2) begin
            rd_entry = vf2_table[entry_idx];
        end else if (sel_qbase) begin
            rd_entry = qbase[host_idx];
        end
    end

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rd_valid <= 1'b0;
        end else begin
            reg_rd_valid <= reg_rd_en;
        end
    end

    always_ff @(posedge core_clk) begin
        if (reg_rd_en) begin
            reg_rdata <= reg_data_wid'(rd_entry);
        end
    end

    // driver side of the register port
    no_rd_wr_overlap_a : assert property (
        @(posedge core_clk) disable iff (!rst_n)
        !(reg_wr_en && reg_rd_en)
    ) else $error("read and write requested in the same cycle");

    wr_in_range_a : assert property (
        @(posedge core_clk) disable iff (!rst_n)
        reg_wr_en |-> reg_addr <= qbase_addr + reg_addr_wid'(num_hosts - 1)
    ) else $error("write beyond the last queue base");

endmodule

//--- hash2qid/hash2qid_lookup.sv
module hash2qid_lookup (
    input  logic                               core_clk,
    input  logic                               rst_n,

    input  logic                               in_valid,
    output logic                               in_ready,
    input  logic [hash2qid_pkg::data_wid-1:0]  in_data,
    input  logic [hash2qid_pkg::keep_wid-1:0]  in_keep,
    input  logic                               in_last,
    input  logic [hash2qid_pkg::tuser_wid-1:0] in_tuser,

    output logic                               out_valid,
    input  logic                               out_ready,
    output logic [hash2qid_pkg::data_wid-1:0]  out_data,
    output logic [hash2qid_pkg::keep_wid-1:0]  out_keep,
    output logic                               out_last,
    output logic [hash2qid_pkg::tuser_wid-1:0] out_tuser,

    input  logic [hash2qid_pkg::qid_wid-1:0]   pf_table  [hash2qid_pkg::tbl_depth],
    input  logic [hash2qid_pkg::qid_wid-1:0]   vf0_table [hash2qid_pkg::tbl_depth],
    input  logic [hash2qid_pkg::qid_wid-1:0]   vf1_table [hash2qid_pkg::tbl_depth],
    input  logic [hash2qid_pkg::qid_wid-1:0]   vf2_table [hash2qid_pkg::tbl_depth],
    input  logic [hash2qid_pkg::qid_wid-1:0]   qbase     [hash2qid_pkg::num_hosts]
);
    import hash2qid_pkg::*;

    tuser_meta_t                      in_meta;
    logic [tbl_index_wid-1:0]         in_index;
    logic [beat_wid+4*qid_wid-1:0]    s1_in;
    logic [beat_wid+4*qid_wid-1:0]    s1_out;
    logic                             s1_valid;
    logic                             s1_ready;
    logic [beat_wid-1:0]              s1_beat;
    logic [qid_wid-1:0]               s1_pf;
    logic [qid_wid-1:0]               s1_vf0;
    logic [qid_wid-1:0]               s1_vf1;
    logic [qid_wid-1:0]               s1_vf2;
    tuser_meta_t                      s1_meta;
    logic [qid_wid-1:0]               entry_sel;
    logic [beat_wid+2*qid_wid-1:0]    s2_out;
    logic                             s2_valid;
    logic                             s2_ready;
    logic [beat_wid-1:0]              s2_beat;
    logic [qid_wid-1:0]               s2_entry;
    logic [qid_wid-1:0]               s2_base;
    logic [qid_wid-1:0]               qid_sum;
    logic [beat_wid+qid_wid-1:0]      s3_out;
    logic [beat_wid-1:0]              s3_beat;
    logic [qid_wid-1:0]               s3_qid;
    tuser_meta_t                      s3_meta;
    tuser_meta_t                      out_meta;

    // ------------------------------------------------------------
    // stage 1: read all four tables at the hashed index
    // ------------------------------------------------------------
    assign in_meta = in_tuser;
    assign in_index = in_meta.rss_word.hash.tbl_index;

    assign s1_in = {in_data, in_keep, in_last, in_tuser,
                    pf_table[in_index], vf0_table[in_index],
                    vf1_table[in_index], vf2_table[in_index]};

    stream_pipe_stage #(
        .width (beat_wid + 4*qid_wid)
    ) stage1_inst (
        .core_clk    (core_clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_payload  (s1_in),
        .out_valid   (s1_valid),
        .out_ready   (s1_ready),
        .out_payload (s1_out)
    );

    assign {s1_beat, s1_pf, s1_vf0, s1_vf1, s1_vf2} = s1_out;
    assign s1_meta = s1_beat[tuser_wid-1:0];

    // ------------------------------------------------------------
    // stage 2: pick the host's entry and fetch its base
    // ------------------------------------------------------------
    always_comb begin
        entry_sel = '0;
        if (s1_meta.rss_enable) begin
            case (s1_meta.rss_word.hash.host_if_id)
                host_pf:  entry_sel = s1_pf;
                host_vf0: entry_sel = s1_vf0;
                host_vf1: entry_sel = s1_vf1;
                host_vf2: entry_sel = s1_vf2;
                default:  entry_sel = '0;
            endcase
        end
    end

    stream_pipe_stage #(
        .width (beat_wid + 2*qid_wid)
    ) stage2_inst (
        .core_clk    (core_clk),
        .rst_n       (rst_n),
        .in_valid    (s1_valid),
        .in_ready    (s1_ready),
        .in_payload  ({s1_beat, entry_sel, qbase[s1_meta.rss_word.hash.host_if_id]}),
        .out_valid   (s2_valid),
        .out_ready   (s2_ready),
        .out_payload (s2_out)
    );

    assign {s2_beat, s2_entry, s2_base} = s2_out;

    // ------------------------------------------------------------
    // stage 3: entry plus base, wraps at 4096
    // ------------------------------------------------------------
    assign qid_sum = s2_entry + s2_base;

    stream_pipe_stage #(
        .width (beat_wid + qid_wid)
    ) stage3_inst (
        .core_clk    (core_clk),
        .rst_n       (rst_n),
        .in_valid    (s2_valid),
        .in_ready    (s2_ready),
        .in_payload  ({s2_beat, qid_sum}),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_payload (s3_out)
    );

    assign {s3_beat, s3_qid} = s3_out;
    assign {out_data, out_keep, out_last, s3_meta} = s3_beat;

    // queue id replaces the hash, flags pass through
    always_comb begin
        out_meta = s3_meta;
        out_meta.rss_enable = 1'b1;
        out_meta.rss_word.qid = s3_qid;
    end

    assign out_tuser = out_meta;

endmodule

//--- hdl/hash2qid_top.sv
module hash2qid_top (
    input  logic                                  core_clk,
    input  logic                                  rst_n,

    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic [hash2qid_pkg::data_wid-1:0]     in_data,
    input  logic [hash2qid_pkg::keep_wid-1:0]     in_keep,
    input  logic                                  in_last,
    input  logic [hash2qid_pkg::tuser_wid-1:0]    in_tuser,

    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic [hash2qid_pkg::data_wid-1:0]     out_data,
    output logic [hash2qid_pkg::keep_wid-1:0]     out_keep,
    output logic                                  out_last,
    output logic [hash2qid_pkg::tuser_wid-1:0]    out_tuser,

    input  logic                                  reg_wr_en,
    input  logic                                  reg_rd_en,
    input  logic [hash2qid_pkg::reg_addr_wid-1:0] reg_addr,
    input  logic [hash2qid_pkg::reg_data_wid-1:0] reg_wdata,
    output logic [hash2qid_pkg::reg_data_wid-1:0] reg_rdata,
    output logic                                  reg_rd_valid
);
    import hash2qid_pkg::*;

    // table contents shared by both blocks
    logic [qid_wid-1:0] pf_table  [tbl_depth];
    logic [qid_wid-1:0] vf0_table [tbl_depth];
    logic [qid_wid-1:0] vf1_table [tbl_depth];
    logic [qid_wid-1:0] vf2_table [tbl_depth];
    logic [qid_wid-1:0] qbase     [num_hosts];

    hash2qid_regs regs_inst (
        .core_clk     (core_clk),
        .rst_n        (rst_n),
        .reg_wr_en    (reg_wr_en),
        .reg_rd_en    (reg_rd_en),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .reg_rd_valid (reg_rd_valid),
        .pf_table     (pf_table),
        .vf0_table    (vf0_table),
        .vf1_table    (vf1_table),
        .vf2_table    (vf2_table),
        .qbase        (qbase)
    );

    hash2qid_lookup lookup_inst (
        .core_clk  (core_clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_keep   (in_keep),
        .in_last   (in_last),
        .in_tuser  (in_tuser),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_last  (out_last),
        .out_tuser (out_tuser),
        .pf_table  (pf_table),
        .vf0_table (vf0_table),
        .vf1_table (vf1_table),
        .vf2_table (vf2_table),
        .qbase     (qbase)
    );

endmodule

//--- verif/hash2qid_tb.sv
module hash2qid_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import hash2qid_pkg::*;

    localparam int num_stim = 24;
    localparam int wait_limit = 200;

    typedef struct packed {
        logic                     rss_en;
        logic [1:0]               host;
        logic [tbl_index_wid-1:0] idx;
        logic [2:0]               flags;
        logic [data_wid-1:0]      data;
        logic [keep_wid-1:0]      keep;
        logic                     last;
    } stim_t;

    logic                    core_clk;
    logic                    rst_n;
    logic                    in_valid;
    logic                    in_ready;
    logic [data_wid-1:0]     in_data;
    logic [keep_wid-1:0]     in_keep;
    logic                    in_last;
    logic [tuser_wid-1:0]    in_tuser;
    logic                    out_valid;
    logic                    out_ready;
    logic [data_wid-1:0]     out_data;
    logic [keep_wid-1:0]     out_keep;
    logic                    out_last;
    logic [tuser_wid-1:0]    out_tuser;
    logic                    reg_wr_en;
    logic                    reg_rd_en;
    logic [reg_addr_wid-1:0] reg_addr;
    logic [reg_data_wid-1:0] reg_wdata;
    logic [reg_data_wid-1:0] reg_rdata;
    logic                    reg_rd_valid;

    stim_t               stim_tbl [num_stim];
    logic [qid_wid-1:0]  ref_tbl  [num_hosts][tbl_depth];
    logic [qid_wid-1:0]  ref_base [num_hosts];
    logic [beat_wid-1:0] exp_q    [$];
    logic [31:0]         lcg_state;
    logic [31:0]         drv_state;
    logic [31:0]         mon_state;

    hash2qid_top hash2qid_top_inst (.*);

    initial begin
        core_clk = 1'b0;
        forever #50 core_clk = ~core_clk;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [reg_addr_wid-1:0] tbl_addr(input int host, input int idx);
        return reg_addr_wid'(host * tbl_depth + idx);
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string msg);
        if (actual !== expected) begin
            fail_now($sformatf("[FAIL] %0d ns: %s: got 0x%0h, expected 0x%0h",
                               $time, msg, actual, expected));
        end
    endtask

    // hash view on the way in, reserved bits left nonzero on purpose
    function automatic logic [tuser_wid-1:0] input_tuser(input stim_t s);
        tuser_meta_t m;
        m.flags = s.flags;
        m.rss_enable = s.rss_en;
        m.rss_word.hash.host_if_id = s.host;
        m.rss_word.hash.reserved = 3'b101;
        m.rss_word.hash.tbl_index = s.idx;
        return m;
    endfunction

    // entry (or 0 when disabled) plus host base, mod 4096
    function automatic logic [beat_wid-1:0] expected_beat(input stim_t s);
        tuser_meta_t        m;
        logic [qid_wid-1:0] entry;
        entry = s.rss_en ? ref_tbl[s.host][s.idx] : '0;
        m.flags = s.flags;
        m.rss_enable = 1'b1;
        m.rss_word.qid = entry + ref_base[s.host];
        return {s.data, s.keep, s.last, m};
    endfunction

    // all register tasks start and end 10 ns after a rising edge
    task automatic reg_write(input logic [reg_addr_wid-1:0] addr, input logic [qid_wid-1:0] val);
        reg_wr_en = 1'b1;
        reg_addr = addr;
        reg_wdata = {20'hf0f0f, val};
        @(posedge core_clk);
        #10;
        reg_wr_en = 1'b0;
    endtask

    task automatic reg_read_check(input logic [reg_addr_wid-1:0] addr,
                                  input logic [qid_wid-1:0] expected);
        reg_rd_en = 1'b1;
        reg_addr = addr;
        @(posedge core_clk);
        #10;
        reg_rd_en = 1'b0;
        check_value(reg_rd_valid, 1'b1, "reg_rd_valid one cycle after read");
        check_value(reg_rdata, 32'(expected), $sformatf("reg_rdata at 0x%0h", addr));
    endtask

    // ------------------------------------------------------------
    // stream driver and monitor
    // ------------------------------------------------------------
    task automatic send_word(input int n);
        int   waited;
        logic accepted;
        waited = 0;
        accepted = 1'b0;
        in_valid = 1'b1;
        in_data = stim_tbl[n].data;
        in_keep = stim_tbl[n].keep;
        in_last = stim_tbl[n].last;
        in_tuser = input_tuser(stim_tbl[n]);
        while (!accepted) begin
            // in_ready is settled by mid-cycle
            #40;
            accepted = in_ready;
            @(posedge core_clk);
            #10;
            waited++;
            if (!accepted && waited > wait_limit) begin
                fail_now("timeout: in_ready stayed low while an input word waited");
            end
        end
        exp_q.push_back(expected_beat(stim_tbl[n]));
        in_valid = 1'b0;
    endtask

    task automatic check_output();
        logic [beat_wid-1:0]  exp;
        logic [data_wid-1:0]  e_data;
        logic [keep_wid-1:0]  e_keep;
        logic                 e_last;
        logic [tuser_wid-1:0] e_tuser;
        if (exp_q.size() == 0) begin
            fail_now("output word arrived while none was expected");
        end
        exp = exp_q.pop_front();
        {e_data, e_keep, e_last, e_tuser} = exp;
        check_value(out_data, e_data, "out_data");
        check_value(out_keep, e_keep, "out_keep");
        check_value(out_last, e_last, "out_last");
        check_value(out_tuser, e_tuser, "out_tuser flags/rss_enable/qid");
    endtask

    task automatic drive_traffic();
        int gap;
        for (int n = 1; n < num_stim; n++) begin
            drv_state = lcg_step(drv_state);
            gap = (drv_state[17:16] == 2'b00) ? int'(drv_state[19:18]) + 1 : 0;
            repeat (gap) begin
                @(posedge core_clk);
                #10;
            end
            send_word(n);
        end
    endtask

    task automatic monitor_traffic(input int count);
        int got;
        int idle;
        got = 0;
        idle = 0;
        while (got < count) begin
            mon_state = lcg_step(mon_state);
            // ready about three cycles in four
            out_ready = mon_state[20] | mon_state[21];
            #40;
            if (out_valid && out_ready) begin
                check_output();
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > wait_limit) begin
                fail_now("timeout: output stream stalled before all words arrived");
            end
            @(posedge core_clk);
            #10;
        end
        out_ready = 1'b1;
    endtask

    // ------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------
    task automatic load_stimulus();
        stim_tbl[0]  = {1'b1, host_pf,  7'd3,   3'd1, 64'h0123_4567_89ab_cdef, 8'hff, 1'b1};
        stim_tbl[1]  = {1'b1, host_pf,  7'd0,   3'd0, 64'h1111_0000_0000_0001, 8'hff, 1'b0};
        stim_tbl[2]  = {1'b1, host_vf0, 7'd17,  3'd2, 64'h2222_0000_0000_0002, 8'hff, 1'b0};
        stim_tbl[3]  = {1'b1, host_vf1, 7'd64,  3'd3, 64'h3333_0000_0000_0003, 8'hff, 1'b0};
        stim_tbl[4]  = {1'b1, host_vf2, 7'd100, 3'd4, 64'h4444_0000_0000_0004, 8'h0f, 1'b1};
        stim_tbl[5]  = {1'b0, host_pf,  7'd5,   3'd5, 64'h5555_0000_0000_0005, 8'hff, 1'b0};
        stim_tbl[6]  = {1'b0, host_vf0, 7'd6,   3'd6, 64'h6666_0000_0000_0006, 8'hff, 1'b0};
        stim_tbl[7]  = {1'b0, host_vf1, 7'd7,   3'd7, 64'h7777_0000_0000_0007, 8'hff, 1'b0};
        stim_tbl[8]  = {1'b0, host_vf2, 7'd8,   3'd0, 64'h8888_0000_0000_0008, 8'h01, 1'b1};
        stim_tbl[9]  = {1'b1, host_pf,  7'd127, 3'd1, 64'h9999_0000_0000_0009, 8'hff, 1'b0};
        stim_tbl[10] = {1'b1, host_vf0, 7'd127, 3'd2, 64'haaaa_0000_0000_000a, 8'hff, 1'b0};
        stim_tbl[11] = {1'b1, host_vf1, 7'd127, 3'd3, 64'hbbbb_0000_0000_000b, 8'hff, 1'b0};
        stim_tbl[12] = {1'b1, host_vf2, 7'd127, 3'd4, 64'hcccc_0000_0000_000c, 8'h3f, 1'b1};
        stim_tbl[13] = {1'b1, host_vf2, 7'd1,   3'd5, 64'hdddd_0000_0000_000d, 8'hff, 1'b0};
        stim_tbl[14] = {1'b1, host_vf1, 7'd2,   3'd6, 64'heeee_0000_0000_000e, 8'hff, 1'b0};
        stim_tbl[15] = {1'b1, host_vf0, 7'd126, 3'd7, 64'hffff_0000_0000_000f, 8'hff, 1'b0};
        stim_tbl[16] = {1'b1, host_pf,  7'd99,  3'd0, 64'hdead_beef_0000_0010, 8'h7f, 1'b1};
        stim_tbl[17] = {1'b0, host_vf2, 7'd127, 3'd1, 64'hcafe_f00d_0000_0011, 8'hff, 1'b0};
        stim_tbl[18] = {1'b1, host_vf0, 7'd42,  3'd2, 64'h0000_0000_ffff_0012, 8'hff, 1'b0};
        stim_tbl[19] = {1'b1, host_vf1, 7'd80,  3'd3, 64'h8000_0000_0000_0013, 8'hff, 1'b1};
        stim_tbl[20] = {1'b1, host_vf2, 7'd33,  3'd4, 64'h0f0f_0f0f_0f0f_0014, 8'hff, 1'b0};
        stim_tbl[21] = {1'b1, host_pf,  7'd64,  3'd5, 64'hf0f0_f0f0_f0f0_0015, 8'hff, 1'b0};
        stim_tbl[22] = {1'b0, host_pf,  7'd127, 3'd6, 64'h1234_5678_0000_0016, 8'hff, 1'b0};
        stim_tbl[23] = {1'b1, host_vf1, 7'd11,  3'd7, 64'h8765_4321_0000_0017, 8'h03, 1'b1};
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        int waited;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_keep = '0;
        in_last = 1'b0;
        in_tuser = '0;
        out_ready = 1'b0;
        reg_wr_en = 1'b0;
        reg_rd_en = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        lcg_state = 32'h611a;
        load_stimulus();
        repeat (3) @(posedge core_clk);
        #10;
        rst_n = 1'b1;

        check_value(out_valid, 1'b0, "out_valid after reset");
        check_value(in_ready, 1'b1, "in_ready after reset");
        check_value(reg_rd_valid, 1'b0, "reg_rd_valid after reset");
        for (int h = 0; h < num_hosts; h++) begin
            for (int i = 0; i < tbl_depth; i++) begin
                reg_read_check(tbl_addr(h, i), '0);
            end
            reg_read_check(qbase_addr + reg_addr_wid'(h), '0);
        end
        // unmapped space
        reg_read_check(10'h204, '0);
        reg_read_check(10'h3ff, '0);

        // last entry of every table forces a wrap, bases are never 0
        for (int h = 0; h < num_hosts; h++) begin
            for (int i = 0; i < tbl_depth; i++) begin
                lcg_state = lcg_step(lcg_state);
                ref_tbl[h][i] = (i == tbl_depth - 1) ? 12'hfff : lcg_state[27:16];
                reg_write(tbl_addr(h, i), ref_tbl[h][i]);
            end
            lcg_state = lcg_step(lcg_state);
            ref_base[h] = lcg_state[27:16] | 12'h001;
            reg_write(qbase_addr + reg_addr_wid'(h), ref_base[h]);
        end
        for (int h = 0; h < num_hosts; h++) begin
            for (int i = 0; i < tbl_depth; i++) begin
                reg_read_check(tbl_addr(h, i), ref_tbl[h][i]);
            end
            reg_read_check(qbase_addr + reg_addr_wid'(h), ref_base[h]);
        end

        // single word, output handshake should land on the third edge
        out_ready = 1'b1;
        send_word(0);
        waited = 0;
        #40;
        while (!out_valid) begin
            @(posedge core_clk);
            #40;
            waited++;
            if (waited > wait_limit) begin
                fail_now("timeout: single word never reached the output");
            end
        end
        check_value(waited + 1, 3, "edges from input transfer to output transfer");
        check_output();
        @(posedge core_clk);
        #10;

        drv_state = lcg_state;
        mon_state = lcg_step(lcg_state ^ 32'h5a5a);
        fork
            drive_traffic();
            monitor_traffic(num_stim - 1);
        join
        check_value(exp_q.size(), 0, "words still expected at end");

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- tb.f
common/hash2qid_pkg.sv
hdl/stream_pipe_stage.sv
hash2qid/hash2qid_regs.sv
hash2qid/hash2qid_lookup.sv
hdl/hash2qid_top.sv
verif/hash2qid_tb.sv
